/* lcd_params.svh */
// Shared defines for the LCD controller
// Bus and character widths, address map
// LCD command bytes and strobe timing in clock cycles

`ifndef LCD_PARAMS_SVH
`define LCD_PARAMS_SVH

//////////////////// Widths
`define LCD_ADDR_W 7                // Character address
`define LCD_DAT_W 8                 // One character
`define WB_DAT_W 32                 // Bus data
`define WB_ADR_W 32                 // Bus address
`define WB_SEL_W 4                  // Byte selects

//////////////////// Address map
`define LCD_LINE_CHARS 16           // Characters per line
`define LCD_LINE2_BASE 7'h40        // First char of line 2
`define LCD_SPECIAL_MASK 32'h80     // Register space select
`define LCD_CMD_REG_ADDR 32'h80     // Command register
`define LCD_BLANK_CHAR 8'h20        // Memory contents before any write

//////////////////// LCD command bytes
`define LCD_CFG_FUNCTION 8'h28      // 4-bit bus, 2 lines, 5x8 font
`define LCD_CFG_ENTRY 8'h06         // Increment, no shift
`define LCD_CFG_DISPLAY 8'h0C       // Display on, cursor off
`define LCD_CFG_CLEAR 8'h01         // Clear display
`define LCD_SET_ADDR1 8'h80         // DDRAM address of line 1
`define LCD_SET_ADDR2 8'hC0         // DDRAM address of line 2

//////////////////// Timing in clocks
`define LCD_SETUP_CYCLES 2          // Data and RS settle before strobe
`define LCD_HOLD_CYCLES 12          // Strobe high time
`define LCD_NIBBLE_GAP_CYCLES 50    // Between high and low nibble
`define LCD_BYTE_GAP_CYCLES 2000    // After each byte
`define LCD_CLEAR_CYCLES 82000      // Clear command execution time
`define LCD_DELAY_W 17              // Fits the clear pause

`endif

/* lcd_pkg.sv */
// Types for the LCD controller
// Character type, sequencer and transmitter states
// Command and status register codes

`include "lcd_params.svh"

package lcd_pkg;

    typedef logic [`LCD_DAT_W-1:0] lcd_char_t;

    // Display sequencer, one state per byte group
    typedef enum logic [3:0] {
        FUNCTION_SET, ENTRY_SET, SET_DISPLAY, CLR_DISPLAY, PAUSE,
        SET_ADDR1, CHAR_WRITE1, SET_ADDR2, CHAR_WRITE2, DONE
    } lcd_seq_state_e;

    // Nibble transmitter
    typedef enum logic [2:0] {
        IDLE, HIGH_SETUP, HIGH_HOLD, NIBBLE_GAP, LOW_SETUP, LOW_HOLD, BYTE_GAP
    } lcd_tx_state_e;

    typedef enum logic [`WB_DAT_W-1:0] {
        CMD_NOP = 'h0,
        CMD_REPAINT = 'h1       // Only command acted on
    } lcd_cmd_e;

    typedef enum logic [`WB_DAT_W-1:0] {
        STATUS_IDLE = 'h0,
        STATUS_BUSY = 'h1
    } lcd_status_e;

endpackage

/* lcd_char_ram.sv */
// Character memory for the two visible lines
// Bus write port, asynchronous read port for the sequencer

`include "lcd_params.svh"

module lcd_char_ram import lcd_pkg::*; (
    input  logic                   clk,
    input  logic                   we_i,
    input  logic [`LCD_ADDR_W-1:0] waddr_i,
    input  lcd_char_t              wdata_i,
    input  logic [`LCD_ADDR_W-1:0] raddr_i,
    output lcd_char_t              rdata_o
);

    lcd_char_t mem [0:2*`LCD_LINE_CHARS-1];  // Line 1 then line 2

    // Index is line bit and column
    logic [4:0] widx;
    logic       wvalid;

    assign widx   = {waddr_i[6], waddr_i[3:0]};
    assign wvalid = (waddr_i[5:4] == 2'b00);  // 0x00-0x0F or 0x40-0x4F only

    initial begin
        for (int i = 0; i < 2*`LCD_LINE_CHARS; i++) mem[i] = `LCD_BLANK_CHAR;  // Blank screen
    end

    always_ff @(posedge clk) begin
        if (we_i && wvalid) mem[widx] <= wdata_i;  // Off-screen writes dropped
    end

    assign rdata_o = mem[{raddr_i[6], raddr_i[3:0]}];

endmodule

/* lcd_nibble_tx.sv */
// Byte transmitter for the 4-bit LCD bus
// Sends high then low nibble, each with setup and strobe hold
// Pulses done after the byte gap

`include "lcd_params.svh"

module lcd_nibble_tx import lcd_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       start_i,     // Accepted in IDLE only
    input  logic       rs_i,
    input  lcd_char_t  byte_i,
    output logic       done_o,
    output logic [3:0] sf_d_o,
    output logic       lcd_e_o,
    output logic       lcd_rs_o
);

    lcd_tx_state_e           state;
    logic [`LCD_DELAY_W-1:0] dly;      // Cycles left in current stage
    lcd_char_t               byte_q;
    logic                    dly_zero;

    assign dly_zero = (dly == '0);

    //////////////////// Control
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state   <= IDLE;
            dly     <= '0;
            lcd_e_o <= 1'b0;
            done_o  <= 1'b0;
        end else begin
            done_o <= 1'b0;                 // Single cycle pulse
            if (state != IDLE && !dly_zero) begin
                dly <= dly - 1'b1;
            end else begin
                case (state)
                    IDLE: if (start_i) begin
                        state <= HIGH_SETUP;
                        dly   <= `LCD_DELAY_W'(`LCD_SETUP_CYCLES - 1);
                    end
                    HIGH_SETUP: begin
                        state   <= HIGH_HOLD;
                        lcd_e_o <= 1'b1;    // Strobe up
                        dly     <= `LCD_DELAY_W'(`LCD_HOLD_CYCLES - 1);
                    end
                    HIGH_HOLD: begin
                        state   <= NIBBLE_GAP;
                        lcd_e_o <= 1'b0;    // Falling edge latches high nibble
                        dly     <= `LCD_DELAY_W'(`LCD_NIBBLE_GAP_CYCLES - 1);
                    end
                    NIBBLE_GAP: begin
                        state <= LOW_SETUP;
                        dly   <= `LCD_DELAY_W'(`LCD_SETUP_CYCLES - 1);
                    end
                    LOW_SETUP: begin
                        state   <= LOW_HOLD;
                        lcd_e_o <= 1'b1;
                        dly     <= `LCD_DELAY_W'(`LCD_HOLD_CYCLES - 1);
                    end
                    LOW_HOLD: begin
                        state   <= BYTE_GAP;
                        lcd_e_o <= 1'b0;    // Low nibble latched
                        dly     <= `LCD_DELAY_W'(`LCD_BYTE_GAP_CYCLES - 1);
                    end
                    BYTE_GAP: begin
                        state  <= IDLE;
                        done_o <= 1'b1;
                    end
                    default: state <= IDLE;
                endcase
            end
        end
    end

    //////////////////// Data path
    // Nibble changes only while the strobe is low
    always_ff @(posedge clk) begin
        if (state == IDLE && start_i) begin
            byte_q   <= byte_i;
            lcd_rs_o <= rs_i;
            sf_d_o   <= byte_i[7:4];       // High nibble first
        end else if (state == NIBBLE_GAP && dly_zero) begin
            sf_d_o <= byte_q[3:0];
        end
    end

endmodule

/* lcd_sequencer.sv */
// Display sequencer
// Configuration bytes, clear pause, then both lines
// from character memory, one byte per transmitter handshake

`include "lcd_params.svh"

module lcd_sequencer import lcd_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   repaint_i,   // Acted on in DONE only
    input  logic                   tx_done_i,
    input  lcd_char_t              rd_data_i,
    output logic                   busy_o,
    output logic                   tx_start_o,
    output logic                   tx_rs_o,
    output lcd_char_t              tx_byte_o,
    output logic [`LCD_ADDR_W-1:0] rd_addr_o
);

    localparam int POS_W = $clog2(`LCD_LINE_CHARS);

    lcd_seq_state_e          state;
    logic                    sent;         // Byte handed to transmitter
    logic [`LCD_DELAY_W-1:0] pause_cnt;
    logic [POS_W-1:0]        pos;          // Column within line
    logic                    byte_state;
    logic                    last_pos;

    assign byte_state = (state != PAUSE) && (state != DONE);
    assign last_pos   = (pos == POS_W'(`LCD_LINE_CHARS - 1));
    assign busy_o     = (state != DONE);

    //////////////////// Byte select
    always_comb begin
        case (state)
            FUNCTION_SET: tx_byte_o = `LCD_CFG_FUNCTION;
            ENTRY_SET:    tx_byte_o = `LCD_CFG_ENTRY;
            SET_DISPLAY:  tx_byte_o = `LCD_CFG_DISPLAY;
            CLR_DISPLAY:  tx_byte_o = `LCD_CFG_CLEAR;
            SET_ADDR1:    tx_byte_o = `LCD_SET_ADDR1;
            SET_ADDR2:    tx_byte_o = `LCD_SET_ADDR2;
            CHAR_WRITE1,
            CHAR_WRITE2:  tx_byte_o = rd_data_i;   // Straight from memory
            default:      tx_byte_o = '0;
        endcase
    end

    // RS high for character data only
    assign tx_rs_o = (state == CHAR_WRITE1) || (state == CHAR_WRITE2);

    // Line 2 starts at its own base
    assign rd_addr_o = (state == CHAR_WRITE2) ?
                       (`LCD_LINE2_BASE + `LCD_ADDR_W'(pos)) : `LCD_ADDR_W'(pos);

    //////////////////// FSM
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state      <= FUNCTION_SET;    // No power-on init, straight to config
            sent       <= 1'b0;
            tx_start_o <= 1'b0;
            pause_cnt  <= '0;
            pos        <= '0;
        end else begin
            tx_start_o <= 1'b0;
            if (byte_state) begin
                if (!sent) begin
                    tx_start_o <= 1'b1;    // Once per byte
                    sent       <= 1'b1;
                end else if (tx_done_i) begin
                    sent <= 1'b0;
                    case (state)
                        FUNCTION_SET: state <= ENTRY_SET;
                        ENTRY_SET:    state <= SET_DISPLAY;
                        SET_DISPLAY:  state <= CLR_DISPLAY;
                        CLR_DISPLAY: begin
                            state     <= PAUSE;
                            pause_cnt <= `LCD_DELAY_W'(`LCD_CLEAR_CYCLES - 1);
                        end
                        SET_ADDR1: begin
                            state <= CHAR_WRITE1;
                            pos   <= '0;
                        end
                        CHAR_WRITE1: begin
                            if (last_pos) state <= SET_ADDR2;
                            else pos <= pos + 1'b1;
                        end
                        SET_ADDR2: begin
                            state <= CHAR_WRITE2;
                            pos   <= '0;
                        end
                        CHAR_WRITE2: begin
                            if (last_pos) state <= DONE;   // Frame complete
                            else pos <= pos + 1'b1;
                        end
                        default: state <= DONE;
                    endcase
                end
            end else if (state == PAUSE) begin
                // Wait out the clear command
                if (pause_cnt == '0) state <= SET_ADDR1;
                else pause_cnt <= pause_cnt - 1'b1;
            end else if (repaint_i) begin
                state <= FUNCTION_SET;     // Full frame again
            end
        end
    end

endmodule

/* wb_lcd.sv */
// Wishbone LCD controller top
// Bus decode, two-cycle ack, status and command registers
// Character memory, display sequencer and nibble transmitter

`include "lcd_params.svh"

module wb_lcd import lcd_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 wb_cyc_i,
    input  logic                 wb_stb_i,
    input  logic                 wb_we_i,
    input  logic [`WB_ADR_W-1:0] wb_adr_i,
    input  logic [`WB_DAT_W-1:0] wb_dat_i,
    input  logic [`WB_SEL_W-1:0] wb_sel_i,   // Accepted, all accesses full width
    output logic                 wb_ack_o,
    output lcd_status_e          wb_dat_o,
    output logic [3:0]           lcd_sf_d_o,
    output logic                 lcd_e_o,
    output logic                 lcd_rs_o,
    output logic                 lcd_rw_o
);

    logic                   cs, wr_commit, special, repaint_req;
    logic                   ram_we, repaint, busy;
    logic [`LCD_ADDR_W-1:0] ram_waddr, rd_addr;
    lcd_char_t              ram_wdata, rd_data, tx_byte;
    logic                   tx_start, tx_rs, tx_done;

    //////////////////// Bus decode
    assign cs          = wb_cyc_i && wb_stb_i;
    assign wr_commit   = cs && wb_we_i && wb_ack_o;   // Write lands on the ack cycle
    assign special     = (wb_adr_i & `LCD_SPECIAL_MASK) != '0;
    assign repaint_req = wr_commit && (wb_adr_i == `LCD_CMD_REG_ADDR) && (wb_dat_i == CMD_REPAINT);

    assign ram_we    = wr_commit && !special;
    assign ram_waddr = wb_adr_i[`LCD_ADDR_W-1:0];
    assign ram_wdata = wb_dat_i[`LCD_DAT_W-1:0];
    assign lcd_rw_o  = 1'b0;                        // Write only

    // Ack toggles so every access takes two cycles
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wb_ack_o <= 1'b0;
            wb_dat_o <= STATUS_BUSY;
            repaint  <= 1'b0;
        end else begin
            wb_ack_o <= cs ? !wb_ack_o : 1'b0;
            wb_dat_o <= busy ? STATUS_BUSY : STATUS_IDLE;   // Any address reads status
            repaint  <= repaint_req && !busy;                // Dropped while a frame runs
        end
    end

    //////////////////// Instances
    lcd_char_ram char_ram_inst (
        .clk(clk), .we_i(ram_we), .waddr_i(ram_waddr), .wdata_i(ram_wdata),
        .raddr_i(rd_addr), .rdata_o(rd_data)
    );

    lcd_sequencer sequencer_inst (
        .clk(clk), .reset(reset), .repaint_i(repaint), .tx_done_i(tx_done),
        .rd_data_i(rd_data), .busy_o(busy), .tx_start_o(tx_start),
        .tx_rs_o(tx_rs), .tx_byte_o(tx_byte), .rd_addr_o(rd_addr)
    );

    lcd_nibble_tx nibble_tx_inst (
        .clk(clk), .reset(reset), .start_i(tx_start), .rs_i(tx_rs),
        .byte_i(tx_byte), .done_o(tx_done), .sf_d_o(lcd_sf_d_o),
        .lcd_e_o(lcd_e_o), .lcd_rs_o(lcd_rs_o)
    );

endmodule

/* wb_lcd_properties.sv */
// Concurrent checks bound into the Wishbone LCD controller
// Single-cycle ack, write-only LCD bus, repaint start

module wb_lcd_properties (
    input logic clk,
    input logic reset,
    input logic wb_ack_i,
    input logic lcd_rw_i,
    input logic repaint_req_i,      // Repaint write on its ack cycle
    input logic busy_i
);

    timeunit 1ns;
    timeprecision 1ps;

    int ack_fails  = 0;
    int rw_fails   = 0;
    int busy_fails = 0;
    int fail_count;

    assign fail_count = ack_fails + rw_fails + busy_fails;

    // Master drops stb right after ack
    ack_single: assert property (@(posedge clk) disable iff (reset) wb_ack_i |=> !wb_ack_i)
        else begin
            ack_fails++;
            $error("wb_ack_o high for two cycles in a row");
        end

    rw_low: assert property (@(posedge clk) lcd_rw_i == 1'b0)
        else begin
            rw_fails++;
            $error("lcd_rw_o not low");
        end

    // Pulse one cycle later, sequencer leaves DONE the next
    repaint_start: assert property (@(posedge clk) disable iff (reset)
                                    (repaint_req_i && !busy_i) |-> ##2 busy_i)
        else begin
            busy_fails++;
            $error("busy did not rise two cycles after a repaint write");
        end

endmodule

bind wb_lcd wb_lcd_properties props_inst (
    .clk(clk), .reset(reset), .wb_ack_i(wb_ack_o), .lcd_rw_i(lcd_rw_o),
    .repaint_req_i(repaint_req), .busy_i(busy)
);

/* tb_wb_lcd.sv */
// Directed testbench for the Wishbone LCD controller
// Bus tasks, LCD bus monitor and screen model
// Reset frame, ack, repaint, ignored write and busy repaint tests

`include "lcd_params.svh"

module tb_wb_lcd import lcd_pkg::*;;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int FRAME_BYTES  = 38;
    localparam int FRAME_CYCLES = FRAME_BYTES * 2100 + `LCD_CLEAR_CYCLES;  // Worst case
    localparam int WATCHDOG_NS  = 5 * FRAME_CYCLES * 8;   // Four frames plus one spare

    logic                 clk = 1'b0;
    logic                 reset;
    logic                 wb_cyc, wb_stb, wb_we;
    logic [`WB_ADR_W-1:0] wb_adr;
    logic [`WB_DAT_W-1:0] wb_dat;
    logic [`WB_SEL_W-1:0] wb_sel;
    logic                 wb_ack;
    lcd_status_e          wb_rdat;
    logic [3:0]           lcd_sf_d;
    logic                 lcd_e, lcd_rs, lcd_rw;

    lcd_char_t  model [0:2*`LCD_LINE_CHARS-1];   // Expected screen, line 1 then line 2
    integer     seed = 32'hd22e;
    logic [8:0] cap_q [$];                       // Captured {rs, byte}
    logic [3:0] high_nib;
    logic       have_high = 1'b0;                // Half a byte seen

    always #4 clk = ~clk;

    wb_lcd wb_lcd_inst (
        .clk(clk), .reset(reset),
        .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_we_i(wb_we),
        .wb_adr_i(wb_adr), .wb_dat_i(wb_dat), .wb_sel_i(wb_sel),
        .wb_ack_o(wb_ack), .wb_dat_o(wb_rdat),
        .lcd_sf_d_o(lcd_sf_d), .lcd_e_o(lcd_e), .lcd_rs_o(lcd_rs), .lcd_rw_o(lcd_rw)
    );

    //////////////////// LCD bus monitor
    // Strobe settling out of reset is not a nibble
    always @(negedge lcd_e) begin
        if (!reset) begin
            check_rs("lcd_rw_o", lcd_rw, 1'b0);  // Write-only bus
            if (!have_high) begin
                high_nib  = lcd_sf_d;                // High nibble comes first
                have_high = 1'b1;
            end else begin
                cap_q.push_back({lcd_rs, high_nib, lcd_sf_d});
                have_high = 1'b0;
            end
        end
    end

    //////////////////// Checks
    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_char(input string name, input lcd_char_t got, input lcd_char_t exp);
        if (got !== exp)
            stop_with_failure($sformatf("Error: %s = 0x%02h, expected 0x%02h", name, got, exp));
    endtask

    task automatic check_rs(input string name, input logic got, input logic exp);
        if (got !== exp)
            stop_with_failure($sformatf("Error: %s = 0x%0h, expected 0x%0h", name, got, exp));
    endtask

    task automatic check_status(input string name, input lcd_status_e got,
                                input lcd_status_e exp);
        if (got !== exp)
            stop_with_failure($sformatf("Error: %s = 0x%08h, expected 0x%08h", name, got, exp));
    endtask

    //////////////////// Bus tasks
    // Called right after a rising edge, returns on one
    task automatic bus_access(input logic write, input logic [`WB_ADR_W-1:0] adr,
                              input logic [`WB_DAT_W-1:0] dat, output lcd_status_e rdata);
        int waited;
        waited = 0;
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we  <= write;
        wb_adr <= adr;
        wb_dat <= dat;
        @(posedge clk);
        while (!wb_ack) begin
            waited++;
            if (waited > 8) stop_with_failure("No bus acknowledge within 8 cycles");
            @(posedge clk);
        end
        rdata = wb_rdat;
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
        @(posedge clk);
        if (wb_ack) stop_with_failure("Bus acknowledge held for a second cycle");
    endtask

    task automatic bus_write(input logic [`WB_ADR_W-1:0] adr, input logic [`WB_DAT_W-1:0] dat);
        lcd_status_e unused;
        bus_access(1'b1, adr, dat, unused);
    endtask

    task automatic bus_read(input logic [`WB_ADR_W-1:0] adr, output lcd_status_e st);
        bus_access(1'b0, adr, '0, st);
    endtask

    // Poll status until the frame is over
    task automatic wait_idle();
        lcd_status_e st;
        do begin
            repeat (50) @(posedge clk);
            bus_read(`LCD_CMD_REG_ADDR, st);
        end while (st != STATUS_IDLE);
    endtask

    function automatic logic [`WB_ADR_W-1:0] char_addr(input int k);
        if (k < `LCD_LINE_CHARS) return `WB_ADR_W'(k);
        return `WB_ADR_W'(`LCD_LINE2_BASE) + `WB_ADR_W'(k - `LCD_LINE_CHARS);
    endfunction

    // Config bytes, line 1 address, 16 chars, line 2 address, 16 chars
    task automatic check_frame();
        logic [8:0] exp_q [$];
        logic [8:0] got;
        exp_q.push_back({1'b0, `LCD_CFG_FUNCTION});
        exp_q.push_back({1'b0, `LCD_CFG_ENTRY});
        exp_q.push_back({1'b0, `LCD_CFG_DISPLAY});
        exp_q.push_back({1'b0, `LCD_CFG_CLEAR});
        exp_q.push_back({1'b0, `LCD_SET_ADDR1});
        for (int k = 0; k < 2*`LCD_LINE_CHARS; k++) begin
            if (k == `LCD_LINE_CHARS) exp_q.push_back({1'b0, `LCD_SET_ADDR2});
            exp_q.push_back({1'b1, model[k]});
        end
        if (cap_q.size() != exp_q.size())
            stop_with_failure($sformatf("LCD frame has %0d bytes instead of %0d",
                                        cap_q.size(), exp_q.size()));
        foreach (exp_q[i]) begin
            got = cap_q.pop_front();
            check_rs("lcd_rs_o", got[8], exp_q[i][8]);
            check_char("lcd_sf_d_o byte", got[7:0], exp_q[i][7:0]);
        end
    endtask

    //////////////////// Tests
    task automatic reset_frame_test();
        lcd_status_e st;
        foreach (model[k]) model[k] = `LCD_BLANK_CHAR;   // Memory before any write
        bus_read(32'h0, st);
        check_status("wb_dat_o", st, STATUS_BUSY);
        wait_idle();
        check_frame();
    endtask

    task automatic ack_test();
        lcd_status_e st;
        bus_read(32'h0, st);             // Status on any address
        check_status("wb_dat_o", st, STATUS_IDLE);
        bus_read(`LCD_CMD_REG_ADDR, st);
        check_status("wb_dat_o", st, STATUS_IDLE);
        bus_read(32'h5a5, st);
        check_status("wb_dat_o", st, STATUS_IDLE);
    endtask

    task automatic repaint_test();
        for (int k = 0; k < 2*`LCD_LINE_CHARS; k++) begin
            model[k] = lcd_char_t'($random(seed));
            bus_write(char_addr(k), {24'h0, model[k]});
        end
        bus_write(`LCD_CMD_REG_ADDR, CMD_REPAINT);
        wait_idle();
        check_frame();
    endtask

    task automatic ignored_write_test();
        lcd_status_e st;
        bus_write(32'h20, 32'h41);       // Off screen
        bus_write(32'h50, 32'h42);
        bus_write(`LCD_CMD_REG_ADDR, CMD_NOP);
        repeat (3000) @(posedge clk);    // Longer than one byte
        if (cap_q.size() != 0 || have_high)
            stop_with_failure("LCD strobe seen after writes that should be ignored");
        bus_read(32'h0, st);
        check_status("wb_dat_o", st, STATUS_IDLE);
        bus_write(`LCD_CMD_REG_ADDR, CMD_REPAINT);
        wait_idle();
        check_frame();
    endtask

    task automatic busy_repaint_test();
        lcd_status_e st;
        bus_write(`LCD_CMD_REG_ADDR, CMD_REPAINT);
        bus_read(32'h0, st);
        check_status("wb_dat_o", st, STATUS_BUSY);
        bus_write(`LCD_CMD_REG_ADDR, CMD_REPAINT);   // Frame already running
        wait_idle();
        check_frame();
        repeat (3000) @(posedge clk);
        if (cap_q.size() != 0 || have_high)
            stop_with_failure("Second LCD frame after a repaint issued while busy");
        bus_read(32'h0, st);
        check_status("wb_dat_o", st, STATUS_IDLE);
    endtask

    initial begin
        #(WATCHDOG_NS);
        stop_with_failure("Timeout, the tests did not finish in time");
    end

    initial begin
        reset  = 1'b1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        wb_adr = '0;
        wb_dat = '0;
        wb_sel = '1;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        reset_frame_test();
        ack_test();
        repaint_test();
        ignored_write_test();
        busy_repaint_test();
        if (wb_lcd_inst.props_inst.fail_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* flist.f */
+incdir+.
lcd_pkg.sv
lcd_char_ram.sv
lcd_nibble_tx.sv
lcd_sequencer.sv
wb_lcd.sv
wb_lcd_properties.sv
tb_wb_lcd.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
verilator --binary --assert --top-module tb_wb_lcd -f flist.f &&
    ./obj_dir/Vtb_wb_lcd | tee /dev/stderr | grep -q "Test passed" ||
    { echo "Simulation did not pass"; exit 1; }
